// File: verif/mapTests.txt
# P drawX drawY layer cursorHit titleBit showMap beginCity endCity pathMask(hex) red green blue
# H cursorX cursorY expectedCity
# Cursor overlay on both pages
P 10 10 0 1 0 0 0 0 00 238 58 140
P 300 20 1 1 1 0 0 0 00 238 58 140
P 569 97 0 1 0 1 1 2 00 238 58 140
P 565 110 2 1 0 1 0 0 01 238 58 140
P 600 400 3 1 0 1 0 0 ff 238 58 140
# Start page layers and title box
P 10 300 0 0 0 0 0 0 00 109 179 89
P 10 300 1 0 0 0 0 0 00 247 248 250
P 10 300 2 0 0 0 0 0 00 217 245 248
P 10 300 3 0 0 0 0 0 00 27 55 73
P 201 0 2 0 1 0 0 0 00 19 104 221
P 400 49 0 0 1 0 0 0 00 19 104 221
P 200 10 1 0 1 0 0 0 00 247 248 250
P 401 10 0 0 1 0 0 0 00 109 179 89
P 300 50 3 0 1 0 0 0 00 27 55 73
P 300 25 2 0 0 0 0 0 00 217 245 248
P 569 97 0 0 0 0 1 2 ff 109 179 89
# Map layer 0 markers
P 569 97 0 0 0 1 1 2 00 255 0 0
P 570 98 0 0 0 1 1 2 00 255 0 0
P 571 97 0 0 0 1 1 2 00 0 0 0
P 562 126 0 0 0 1 1 2 00 0 255 255
P 478 199 0 0 0 1 5 5 00 0 255 255
P 569 97 0 0 0 1 0 2 00 0 0 0
# Map layers 1 to 3
P 565 110 2 0 0 1 0 0 01 0 0 255
P 500 250 2 0 0 1 0 0 80 0 0 255
P 489 229 2 0 0 1 0 0 20 0 0 255
P 470 190 2 0 0 1 0 0 f7 85 109 75
P 100 100 2 0 0 1 0 0 ff 85 109 75
P 569 97 1 0 0 1 1 2 ff 255 255 255
P 569 110 3 0 0 1 0 0 ff 255 195 195
# Hover lookup at each city centre
H 569 97 1
H 563 125 2
H 547 160 3
H 465 186 4
H 478 199 5
H 489 229 6
H 527 235 7
H 478 219 8
H 100 100 0

// File: tb.f
src/mapPkg.sv
src/pixelClassifier.sv
src/pixelFifo.sv
src/colorResolver.sv
src/cursorCityFinder.sv
src/mapRenderer.sv
verif/mapRenderer_assert.sv
verif/mapRendererTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mapRendererTb -f tb.f -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log
then
    exit 1
fi

// File: verif/mapRendererTb.sv
`timescale 1ns/1ps

module mapRendererTb;
    import mapPkg::*;

    localparam int HALF_PERIOD = 20;            // 40 ns clock
    localparam int DRIVE_DELAY = 1;             // After rising edge
    localparam int WAIT_LIMIT  = 200;           // Cycles per wait
    localparam int LATENCY     = 3;             // Accept to output with rgbReady high

    typedef struct packed {
        pixelReqT req;
        cityIdT   beginCity;
        cityIdT   endCity;
        segMaskT  pathMask;
        rgbT      expRgb;
    } pixelTestT;

    typedef struct packed {
        coordT  x;
        coordT  y;
        cityIdT city;
    } hoverTestT;

    logic     clk;
    logic     arstN;
    logic     reqValid;
    logic     reqReady;
    pixelReqT req;
    cityIdT   beginCity;
    cityIdT   endCity;
    segMaskT  pathMask;
    logic     rgbValid;
    logic     rgbReady = 1'b1;
    rgbT      rgb;
    coordT    cursorX;
    coordT    cursorY;
    cityIdT   hoverCity;

    pixelTestT pixelTests [$];
    hoverTestT hoverTests [$];
    rgbT       expQueue [$];                    // Colours still owed, in order
    int        acceptQueue [$];                 // Cycle of each accepted request
    int        cycleCount   = 0;
    int        errors       = 0;
    integer    seed         = 97;
    logic      randomReady  = 1'b0;
    logic      checkLatency = 1'b0;
    cityIdT    lastHover    = '0;

    mapRenderer #(
        .FIFO_DEPTH (FIFO_DEPTH_DEFAULT)
    ) mapRenderer_i (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .beginCity (beginCity),
        .endCity   (endCity),
        .pathMask  (pathMask),
        .rgbValid  (rgbValid),
        .rgbReady  (rgbReady),
        .rgb       (rgb),
        .cursorX   (cursorX),
        .cursorY   (cursorY),
        .hoverCity (hoverCity)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    // Output back-pressure
    always @(posedge clk)
    begin
        #DRIVE_DELAY;
        rgbReady = randomReady ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic finishRun();
        int total;
        total = errors + mapRenderer_i.handshakeChecks.failures;
        $display("Errors: %0d (testbench %0d, assertions %0d)", total, errors,
                 mapRenderer_i.handshakeChecks.failures);
        if (total == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic loadTests();
        int        fd;
        int        items;
        string     line;
        string     kind;
        int        f [12];
        pixelTestT p;
        hoverTestT h;
        fd = $fopen("verif/mapTests.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("ERROR: cannot open verif/mapTests.txt");
        end
        while (fd != 0 && !$feof(fd))
        begin
            line  = "";
            items = $fgets(line, fd);
            if ($sscanf(line, "%s", kind) != 1 || kind == "#")
            begin
                continue;                       // Blank or comment
            end
            if (kind == "P")
            begin
                items = $sscanf(line, "%s %d %d %d %d %d %d %d %d %h %d %d %d", kind,
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11]);
                if (items != 13)
                begin
                    errors++;
                    $display("ERROR: malformed pixel line: %s", line);
                    continue;
                end
                p.req.drawX     = coordT'(f[0]);
                p.req.drawY     = coordT'(f[1]);
                p.req.layer     = layerT'(f[2]);
                p.req.cursorHit = f[3][0];
                p.req.titleBit  = f[4][0];
                p.req.showMap   = f[5][0];
                p.beginCity     = cityIdT'(f[6]);
                p.endCity       = cityIdT'(f[7]);
                p.pathMask      = segMaskT'(f[8]);
                p.expRgb.red    = 8'(f[9]);
                p.expRgb.green  = 8'(f[10]);
                p.expRgb.blue   = 8'(f[11]);
                pixelTests.push_back(p);
            end
            else if (kind == "H")
            begin
                items = $sscanf(line, "%s %d %d %d", kind, f[0], f[1], f[2]);
                if (items != 4)
                begin
                    errors++;
                    $display("ERROR: malformed hover line: %s", line);
                    continue;
                end
                h.x    = coordT'(f[0]);
                h.y    = coordT'(f[1]);
                h.city = cityIdT'(f[2]);
                hoverTests.push_back(h);
            end
            else
            begin
                errors++;
                $display("ERROR: unknown line kind in test file: %s", line);
            end
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
        if (pixelTests.size() == 0 || hoverTests.size() == 0)
        begin
            errors++;
            $display("ERROR: test file holds no pixel or no hover tests");
        end
    endtask

    // --------------------------------------------------
    // Pixel stream
    // --------------------------------------------------
    task automatic sendPixel(input pixelTestT t);
        int waited;
        waited    = 0;
        req       = t.req;
        beginCity = t.beginCity;
        endCity   = t.endCity;
        pathMask  = t.pathMask;
        reqValid  = 1'b1;
        @(negedge clk);
        while (!reqReady && waited < WAIT_LIMIT)
        begin
            waited++;
            @(negedge clk);
        end
        if (!reqReady)
        begin
            errors++;
            $display("ERROR: timed out waiting for reqReady at %0t", $time);
        end
        else
        begin
            expQueue.push_back(t.expRgb);
            acceptQueue.push_back(cycleCount);  // Transfer on the coming edge
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic streamPixels();
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (pixelTests[i])
        begin
            sendPixel(pixelTests[i]);
        end
        reqValid = 1'b0;
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (expQueue.size() != 0 && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (expQueue.size() != 0)
        begin
            errors++;
            $display("ERROR: timed out with %0d colours never delivered", expQueue.size());
            expQueue.delete();
            acceptQueue.delete();
        end
        @(negedge clk);
    endtask

    always @(negedge clk)
    begin : monitorOutputs
        rgbT expRgb;
        int  acceptCycle;
        if (arstN && rgbValid && rgbReady)
        begin
            if (expQueue.size() == 0)
            begin
                errors++;
                $display("ERROR: colour delivered at %0t with no pixel outstanding", $time);
            end
            else
            begin
                expRgb      = expQueue.pop_front();
                acceptCycle = acceptQueue.pop_front();
                compareValue("rgb", {8'd0, rgb}, {8'd0, expRgb});
                if (checkLatency)
                begin
                    compareValue("latency", cycleCount - acceptCycle, LATENCY);
                end
            end
        end
    end

    // --------------------------------------------------
    // Hover lookup
    // --------------------------------------------------
    task automatic sweepHover(input hoverTestT t);
        cityIdT expCity;
        for (int dy = -2; dy <= 2; dy++)
        begin
            for (int dx = -2; dx <= 2; dx++)
            begin
                expCity = (dx >= -1 && dx <= 1 && dy >= -1 && dy <= 1) ? t.city : '0;
                cursorX = coordT'(int'(t.x) + dx);
                cursorY = coordT'(int'(t.y) + dy);
                @(negedge clk);
                compareValue("hoverCity before edge", {28'd0, hoverCity}, {28'd0, lastHover});
                @(posedge clk);
                @(negedge clk);
                compareValue("hoverCity", {28'd0, hoverCity}, {28'd0, expCity});
                lastHover = expCity;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
    endtask

    initial
    begin : mainSequence
        arstN     = 1'b0;
        reqValid  = 1'b0;
        req       = '0;
        beginCity = '0;
        endCity   = '0;
        pathMask  = '0;
        cursorX   = '0;
        cursorY   = '0;
        loadTests();
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;

        checkLatency = 1'b1;                    // Full rate first
        streamPixels();
        drainOutputs();
        checkLatency = 1'b0;
        randomReady  = 1'b1;                    // Then random stalls
        streamPixels();
        drainOutputs();
        randomReady  = 1'b0;

        @(posedge clk);
        #DRIVE_DELAY;
        foreach (hoverTests[i])
        begin
            sweepHover(hoverTests[i]);
        end
        finishRun();
    end

endmodule

// File: verif/mapRenderer_assert.sv
`timescale 1ns/1ps

module mapRenderer_assert (
    input logic             clk,
    input logic             arstN,
    input logic             reqValid,
    input logic             reqReady,
    input mapPkg::pixelReqT req,
    input logic             tagValid,
    input logic             tagReady,
    input mapPkg::pixelTagT tag,
    input logic             fifoValid,
    input logic             fifoReady,
    input mapPkg::pixelTagT fifoTag,
    input logic             rgbValid,
    input logic             rgbReady,
    input mapPkg::rgbT      rgb,
    input mapPkg::cityIdT   hoverCity
);
    import mapPkg::*;

    int failures = 0;

    // --------------------------------------------------
    // Streams hold while stalled
    // --------------------------------------------------
    reqHold: assert property (@(posedge clk) disable iff (!arstN)
        reqValid && !reqReady |=> reqValid && $stable(req))
        else
        begin
            failures++;
            $error("req changed while stalled");
        end

    tagHold: assert property (@(posedge clk) disable iff (!arstN)
        tagValid && !tagReady |=> tagValid && $stable(tag))
        else
        begin
            failures++;
            $error("tag changed while stalled");
        end

    fifoHold: assert property (@(posedge clk) disable iff (!arstN)
        fifoValid && !fifoReady |=> fifoValid && $stable(fifoTag))
        else
        begin
            failures++;
            $error("fifoTag changed while stalled");
        end

    rgbHold: assert property (@(posedge clk) disable iff (!arstN)
        rgbValid && !rgbReady |=> rgbValid && $stable(rgb))
        else
        begin
            failures++;
            $error("rgb changed while stalled");
        end

    quietInReset: assert property (@(posedge clk) !arstN |-> !rgbValid)
        else
        begin
            failures++;
            $error("rgbValid high during reset");
        end

    hoverRange: assert property (@(posedge clk) hoverCity <= cityIdT'(NUM_CITIES))
        else
        begin
            failures++;
            $error("hoverCity out of range");
        end

endmodule

bind mapRenderer mapRenderer_assert handshakeChecks (.*);

// File: src/mapRenderer.sv
`timescale 1ns/1ps

module mapRenderer #(
    parameter int FIFO_DEPTH = mapPkg::FIFO_DEPTH_DEFAULT
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             reqValid,
    output logic             reqReady,
    input  mapPkg::pixelReqT req,
    input  mapPkg::cityIdT   beginCity,
    input  mapPkg::cityIdT   endCity,
    input  mapPkg::segMaskT  pathMask,
    output logic             rgbValid,
    input  logic             rgbReady,
    output mapPkg::rgbT      rgb,
    input  mapPkg::coordT    cursorX,
    input  mapPkg::coordT    cursorY,
    output mapPkg::cityIdT   hoverCity
);
    import mapPkg::*;

    // --------------------------------------------------
    // Pixel pipeline
    // --------------------------------------------------
    logic     tagValid;
    logic     tagReady;
    pixelTagT tag;
    logic     fifoValid;
    logic     fifoReady;
    pixelTagT fifoTag;

    pixelClassifier pixelClassifier_i (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .beginCity (beginCity),
        .endCity   (endCity),
        .pathMask  (pathMask),
        .tagValid  (tagValid),
        .tagReady  (tagReady),
        .tag       (tag)
    );

    pixelFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pixelFifo_i (
        .clk       (clk),
        .arstN     (arstN),
        .tagValid  (tagValid),
        .tagReady  (tagReady),
        .tag       (tag),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady),
        .fifoTag   (fifoTag)
    );

    colorResolver colorResolver_i (
        .clk       (clk),
        .arstN     (arstN),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady),
        .fifoTag   (fifoTag),
        .rgbValid  (rgbValid),
        .rgbReady  (rgbReady),
        .rgb       (rgb)
    );

    // Hover lookup runs beside the pipeline
    cursorCityFinder cursorCityFinder_i (
        .clk       (clk),
        .arstN     (arstN),
        .cursorX   (cursorX),
        .cursorY   (cursorY),
        .hoverCity (hoverCity)
    );

endmodule

// File: src/cursorCityFinder.sv
`timescale 1ns/1ps

module cursorCityFinder (
    input  logic           clk,
    input  logic           arstN,
    input  mapPkg::coordT  cursorX,
    input  mapPkg::coordT  cursorY,
    output mapPkg::cityIdT hoverCity
);
    import mapPkg::*;

    cityIdT hitId;

    // Later entries overwrite, so highest id wins
    always_comb
    begin
        hitId = '0;
        for (int i = 0; i < NUM_CITIES; i++)
        begin
            if (nearCity(cursorX, cursorY, cityTable[i]))
            begin
                hitId = cityIdT'(i + 1);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hoverCity <= '0;
        end
        else
        begin
            hoverCity <= hitId;                 // One cycle behind cursor
        end
    end

endmodule

// File: src/colorResolver.sv
`timescale 1ns/1ps

module colorResolver (
    input  logic             clk,
    input  logic             arstN,
    input  logic             fifoValid,
    output logic             fifoReady,
    input  mapPkg::pixelTagT fifoTag,
    output logic             rgbValid,
    input  logic             rgbReady,
    output mapPkg::rgbT      rgb
);
    import mapPkg::*;

    rgbT nextRgb;

    // --------------------------------------------------
    // Colour priority
    // --------------------------------------------------
    always_comb
    begin
        if (fifoTag.cursorHit)
        begin
            nextRgb = cursorColor;              // Cursor over everything
        end
        else if (!fifoTag.showMap)
        begin
            // Start page
            if (fifoTag.onTitle)
            begin
                nextRgb = titleColor;
            end
            else
            begin
                nextRgb = startColors[fifoTag.layer];
            end
        end
        else
        begin
            case (fifoTag.layer)
                2'd0:
                begin
                    if (fifoTag.onEnd)
                    begin
                        nextRgb = endColor;     // End marker on top
                    end
                    else if (fifoTag.onBegin)
                    begin
                        nextRgb = beginColor;
                    end
                    else
                    begin
                        nextRgb = mapBlack;
                    end
                end
                2'd1:
                begin
                    nextRgb = mapWhite;
                end
                2'd2:
                begin
                    nextRgb = fifoTag.onPath ? pathColor : landColor;
                end
                default:
                begin
                    nextRgb = panelColor;       // Info panel
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    assign fifoReady = !rgbValid || rgbReady;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rgbValid <= 1'b0;
        end
        else if (fifoReady)
        begin
            rgbValid <= fifoValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifoValid && fifoReady)
        begin
            rgb <= nextRgb;
        end
    end

endmodule

// File: src/pixelFifo.sv
`timescale 1ns/1ps

module pixelFifo #(
    parameter int FIFO_DEPTH = mapPkg::FIFO_DEPTH_DEFAULT
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             tagValid,
    output logic             tagReady,
    input  mapPkg::pixelTagT tag,
    output logic             fifoValid,
    input  logic             fifoReady,
    output mapPkg::pixelTagT fifoTag
);
    import mapPkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pixelTagT         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             wrEn;
    logic             rdEn;

    assign tagReady  = (count != CNT_W'(FIFO_DEPTH));   // Full blocks writes
    assign fifoValid = (count != '0);
    assign fifoTag   = mem[rdPtr];                      // Head of queue
    assign wrEn      = tagValid && tagReady;
    assign rdEn      = fifoValid && fifoReady;

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            mem[wrPtr] <= tag;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (wrEn)
            begin
                wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn)
            begin
                rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

// File: src/pixelClassifier.sv
`timescale 1ns/1ps

module pixelClassifier (
    input  logic             clk,
    input  logic             arstN,
    input  logic             reqValid,
    output logic             reqReady,
    input  mapPkg::pixelReqT req,
    input  mapPkg::cityIdT   beginCity,
    input  mapPkg::cityIdT   endCity,
    input  mapPkg::segMaskT  pathMask,
    output logic             tagValid,
    input  logic             tagReady,
    output mapPkg::pixelTagT tag
);
    import mapPkg::*;

    pixelTagT nextTag;
    logic     onBegin;
    logic     onEnd;
    logic     onPath;
    logic     onTitle;

    // Hit test for the 3x3 marker box around a city id
    function automatic logic markerHit(coordT px, coordT py, cityIdT id);
        cityPosT pos;
        if (id == '0 || id > NUM_CITIES)
        begin
            return 1'b0;
        end
        pos = cityTable[3'(id - 1'b1)];
        return nearCity(px, py, pos);
    endfunction

    // --------------------------------------------------
    // Geometry flags
    // --------------------------------------------------
    always_comb
    begin
        onPath = 1'b0;
        for (int i = 0; i < NUM_SEGMENTS; i++)
        begin
            if (pathMask[i] && inRect(req.drawX, req.drawY, segmentTable[i]))
            begin
                onPath = 1'b1;                  // Any enabled segment
            end
        end
    end

    assign onBegin = markerHit(req.drawX, req.drawY, beginCity);
    assign onEnd   = markerHit(req.drawX, req.drawY, endCity);
    assign onTitle = req.titleBit && inRect(req.drawX, req.drawY, titleBox);

    always_comb
    begin
        nextTag.layer     = req.layer;
        nextTag.cursorHit = req.cursorHit;
        nextTag.showMap   = req.showMap;
        nextTag.onTitle   = onTitle;
        nextTag.onBegin   = onBegin;
        nextTag.onEnd     = onEnd;
        nextTag.onPath    = onPath;
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    assign reqReady = !tagValid || tagReady;    // Empty or draining

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            tagValid <= 1'b0;
        end
        else if (reqReady)
        begin
            tagValid <= reqValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reqValid && reqReady)
        begin
            tag <= nextTag;                     // Load on accept
        end
    end

endmodule

// File: src/mapPkg.sv
package mapPkg;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [9:0] coordT;     // Screen x or y
    typedef logic [3:0] cityIdT;    // 0 means no city
    typedef logic [1:0] layerT;     // Background layer code
    typedef logic [7:0] segMaskT;   // One bit per route segment

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    typedef struct packed {
        coordT drawX;
        coordT drawY;
        layerT layer;
        logic  cursorHit;           // Cursor sprite covers pixel
        logic  titleBit;            // Title glyph bit
        logic  showMap;             // Map page when set
    } pixelReqT;

    typedef struct packed {
        layerT layer;
        logic  cursorHit;
        logic  showMap;
        logic  onTitle;
        logic  onBegin;
        logic  onEnd;
        logic  onPath;
    } pixelTagT;

    typedef struct packed {
        coordT x;
        coordT y;
    } cityPosT;

    typedef struct packed {
        coordT xMin;
        coordT xMax;
        coordT yMin;
        coordT yMax;
    } segRectT;

    // --------------------------------------------------
    // Network tables
    // --------------------------------------------------
    localparam int NUM_CITIES         = 8;
    localparam int NUM_SEGMENTS       = 8;
    localparam int FIFO_DEPTH_DEFAULT = 4;

    // Entry i holds city id i+1
    localparam cityPosT cityTable [NUM_CITIES] = '{
        '{10'd569, 10'd97},         // Haerbin
        '{10'd563, 10'd125},        // Changchun
        '{10'd547, 10'd160},        // Shenyang
        '{10'd465, 10'd186},        // Beijing
        '{10'd478, 10'd199},        // Tianjin
        '{10'd489, 10'd229},        // Jinan
        '{10'd527, 10'd235},        // Qingdao
        '{10'd478, 10'd219}         // Dezhou
    };

    localparam segRectT segmentTable [NUM_SEGMENTS] = '{
        '{10'd563, 10'd569, 10'd97,  10'd125},  // Haerbin to Changchun
        '{10'd547, 10'd563, 10'd125, 10'd160},  // Changchun to Shenyang
        '{10'd497, 10'd545, 10'd153, 10'd160},  // Shenyang to Beijing
        '{10'd465, 10'd478, 10'd188, 10'd199},  // Beijing to Tianjin
        '{10'd477, 10'd479, 10'd199, 10'd219},  // Tianjin to Dezhou
        '{10'd478, 10'd489, 10'd219, 10'd229},  // Dezhou to Jinan
        '{10'd492, 10'd520, 10'd228, 10'd230},  // Jinan to Qingdao
        '{10'd491, 10'd511, 10'd231, 10'd284}   // Jinan to Nanjing
    };

    localparam segRectT titleBox = '{10'd201, 10'd400, 10'd0, 10'd49};

    // --------------------------------------------------
    // Palette
    // --------------------------------------------------
    localparam rgbT cursorColor    = '{8'd238, 8'd58,  8'd140};
    localparam rgbT startColors [4] = '{
        '{8'd109, 8'd179, 8'd89},
        '{8'd247, 8'd248, 8'd250},
        '{8'd217, 8'd245, 8'd248},
        '{8'd27,  8'd55,  8'd73}
    };
    localparam rgbT titleColor     = '{8'd19,  8'd104, 8'd221};
    localparam rgbT mapBlack       = '{8'd0,   8'd0,   8'd0};
    localparam rgbT beginColor     = '{8'd255, 8'd0,   8'd0};
    localparam rgbT endColor       = '{8'd0,   8'd255, 8'd255};
    localparam rgbT mapWhite       = '{8'd255, 8'd255, 8'd255};
    localparam rgbT landColor      = '{8'd85,  8'd109, 8'd75};
    localparam rgbT pathColor      = '{8'd0,   8'd0,   8'd255};
    localparam rgbT panelColor     = '{8'd255, 8'd195, 8'd195};

    // Point within 1 pixel of a city in both axes
    function automatic logic nearCity(coordT px, coordT py, cityPosT city);
        return ({1'b0, px} + 11'd1 >= {1'b0, city.x}) && ({1'b0, px} <= {1'b0, city.x} + 11'd1)
            && ({1'b0, py} + 11'd1 >= {1'b0, city.y}) && ({1'b0, py} <= {1'b0, city.y} + 11'd1);
    endfunction

    // Inclusive rectangle test
    function automatic logic inRect(coordT px, coordT py, segRectT r);
        return (px >= r.xMin) && (px <= r.xMax) && (py >= r.yMin) && (py <= r.yMax);
    endfunction

endpackage
